// ==== mem_cfg.svh ====
// Memory widths, burst length, client count, region map, rectangle geometry and fill colour
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Word address and data widths
`define MEM_AW 12
`define MEM_DW 16

// Words returned by every read request
`define MEM_BURST 8
`define MEM_CLIENTS 4

// Frame region, 8 lines of 32 words
`define FRAME_BASE 12'h400
`define LINE_STRIDE 32
`define FRAME_WORDS 256

// Border rectangle, offsets and sizes in words and lines
`define RECT_X 3
`define RECT_Y 2
`define RECT_W 20
`define RECT_H 5
`define FILL_COLOUR 16'h0841

// Tester region, clear of the frame
`define TEST_BASE 12'h800
`define TEST_WORDS 64

`endif

// ==== mem_pkg.sv ====
// Client request, read response and client index types for the shared memory
`include "mem_cfg.svh"

package mem_pkg;

// Client index, doubles as arbiter rotation position
typedef logic [1:0] client_id_t;

localparam client_id_t CL_EXT = 2'd0;
localparam client_id_t CL_RECT = 2'd1;
localparam client_id_t CL_TEST = 2'd2;
localparam client_id_t CL_SCAN = 2'd3;

// One client request, held stable while req is high
typedef struct packed {
	logic [`MEM_AW-1:0] addr;
	logic [`MEM_DW-1:0] data;
	logic wr;
} mem_req_t;

// Shared read return bus
// valid has one bit per client, only the burst owner's bit rises
typedef struct packed {
	logic [`MEM_DW-1:0] data;
	logic [`MEM_CLIENTS-1:0] valid;
} mem_rsp_t;

endpackage

// ==== mem_arbiter.sv ====
// Rotating-priority arbiter selecting one memory client while the memory is idle
`include "mem_cfg.svh"

module mem_arbiter import mem_pkg::*; (
	input logic CLOCK_50,
	input logic rst_n,
	input logic [`MEM_CLIENTS-1:0] req,
	input mem_req_t reqs [`MEM_CLIENTS],
	input logic idle,
	output logic grant,
	output client_id_t gnt_id,
	output mem_req_t gnt_req
);

// Index of the client granted most recently
client_id_t last;
client_id_t cand;
logic found;

// Search starts one past the last winner and wraps around,
// so the last winner itself is checked at the very end
always_comb begin
	found = 1'b0;
	gnt_id = last;
	cand = last;
	for (int i = 1; i <= `MEM_CLIENTS; i++) begin
		cand = client_id_t'((int'(last) + i) % `MEM_CLIENTS);
		if (!found && req[cand]) begin
			found = 1'b1;
			gnt_id = cand;
		end
	end
end

// Grant only between bursts
assign grant = idle && found;
assign gnt_req = reqs[gnt_id];

// Rotate priority past the winner
always_ff @(posedge CLOCK_50 or negedge rst_n) begin
	if (!rst_n)
		last <= client_id_t'(`MEM_CLIENTS - 1);
	else if (grant)
		last <= gnt_id;
end

endmodule

// ==== frame_memory.sv ====
// On-chip word RAM with single-word writes, burst read sequencer and client arbiter
`include "mem_cfg.svh"

module frame_memory import mem_pkg::*; (
	input logic CLOCK_50,
	input logic rst_n,
	input logic [`MEM_CLIENTS-1:0] req,
	input mem_req_t reqs [`MEM_CLIENTS],
	output logic [`MEM_CLIENTS-1:0] ack,
	output mem_rsp_t rsp
);

localparam int DEPTH = 1 << `MEM_AW;
localparam int CW = $clog2(`MEM_BURST);
localparam int NC = `MEM_CLIENTS;

logic [`MEM_DW-1:0] ram [DEPTH];

// Arbiter results
logic grant;
logic idle;
client_id_t gnt_id;
mem_req_t gnt_req;

// Burst sequencer
logic busy;
logic [`MEM_AW-1:0] seq_addr;
logic [CW-1:0] seq_cnt;
client_id_t seq_owner;

// Registered read return
logic [`MEM_DW-1:0] rd_data;
logic [NC-1:0] rd_valid;

mem_arbiter i_arbiter (
	.CLOCK_50(CLOCK_50),
	.rst_n(rst_n),
	.req(req),
	.reqs(reqs),
	.idle(idle),
	.grant(grant),
	.gnt_id(gnt_id),
	.gnt_req(gnt_req)
);

// Busy until the last word of a burst has left the output register
assign idle = !busy && rd_valid == '0;
assign ack = grant ? (NC'(1) << gnt_id) : '0;
assign rsp = '{data: rd_data, valid: rd_valid};

// Writes land in the ack cycle, reads follow the sequencer address
always_ff @(posedge CLOCK_50) begin
	if (grant && gnt_req.wr)
		ram[gnt_req.addr] <= gnt_req.data;
	rd_data <= ram[seq_addr];
end

// Read word k is addressed k+1 cycles after ack and returned one cycle later
always_ff @(posedge CLOCK_50 or negedge rst_n) begin
	if (!rst_n) begin
		busy <= 1'b0;
		seq_addr <= '0;
		seq_cnt <= '0;
		seq_owner <= CL_EXT;
		rd_valid <= '0;
	end else begin
		rd_valid <= busy ? (NC'(1) << seq_owner) : '0;
		if (grant && !gnt_req.wr) begin
			busy <= 1'b1;
			seq_addr <= gnt_req.addr;
			seq_cnt <= '0;
			seq_owner <= gnt_id;
		end else if (busy) begin
			seq_addr <= seq_addr + 1'b1;
			seq_cnt <= seq_cnt + 1'b1;
			if (seq_cnt == CW'(`MEM_BURST - 1))
				busy <= 1'b0;
		end
	end
end

endmodule

// ==== rect_fill.sv ====
// Rectangle filler writing a solid colour into the frame region line by line
`include "mem_cfg.svh"

module rect_fill import mem_pkg::*; (
	input logic CLOCK_50,
	input logic rst_n,
	input logic start,
	output logic req,
	output mem_req_t req_data,
	input logic ack,
	output logic active
);

localparam int AW = `MEM_AW;
localparam int XW = $clog2(`RECT_W + 1);
localparam int YW = $clog2(`RECT_H + 1);

// Column and line inside the rectangle
logic [XW-1:0] x;
logic [YW-1:0] y;
// Word offset of the current line from the frame base
logic [AW-1:0] line_off;

always_ff @(posedge CLOCK_50 or negedge rst_n) begin
	if (!rst_n) begin
		active <= 1'b0;
		x <= '0;
		y <= '0;
		line_off <= '0;
	end else if (!active) begin
		if (start) begin
			active <= 1'b1;
			x <= '0;
			y <= '0;
			line_off <= AW'(`RECT_Y * `LINE_STRIDE);
		end
	end else if (ack) begin
		if (x == XW'(`RECT_W - 1)) begin
			// End of line, step to the next one
			x <= '0;
			line_off <= line_off + AW'(`LINE_STRIDE);
			if (y == YW'(`RECT_H - 1))
				active <= 1'b0;
			else
				y <= y + 1'b1;
		end else begin
			x <= x + 1'b1;
		end
	end
end

// One write outstanding whenever running
assign req = active;
assign req_data = '{
	addr: AW'(`FRAME_BASE) + line_off + AW'(`RECT_X) + AW'(x),
	data: `MEM_DW'(`FILL_COLOUR),
	wr: 1'b1
};

endmodule

// ==== mem_test.sv ====
// Memory tester writing an address pattern, reading it back in bursts and flagging mismatches
`include "mem_cfg.svh"

module mem_test import mem_pkg::*; (
	input logic CLOCK_50,
	input logic rst_n,
	input logic start,
	output logic req,
	output mem_req_t req_data,
	input logic ack,
	input mem_rsp_t rsp,
	output logic done,
	output logic fail
);

localparam int AW = `MEM_AW;
localparam int TW = $clog2(`TEST_WORDS);
localparam int BW = $clog2(`MEM_BURST);

typedef enum logic [1:0] {
	T_IDLE,
	T_WRITE,
	T_READ,
	T_WAIT
} state_t;

state_t state;
// Write offset, then offset of the next read burst
logic [TW-1:0] ofs;
// Offset of the next word expected back
logic [TW-1:0] chk_ofs;
logic [AW-1:0] req_addr;
logic [AW-1:0] chk_addr;
logic hit;

// Expected content of a word
function automatic logic [`MEM_DW-1:0] pattern(input logic [`MEM_AW-1:0] a);
	return `MEM_DW'(a) ^ 16'h5a5a;
endfunction

assign req_addr = AW'(`TEST_BASE) + AW'(ofs);
assign chk_addr = AW'(`TEST_BASE) + AW'(chk_ofs);
assign hit = rsp.valid[CL_TEST];

assign req = state == T_WRITE || state == T_READ;
assign req_data = '{addr: req_addr, data: pattern(req_addr), wr: state == T_WRITE};

always_ff @(posedge CLOCK_50 or negedge rst_n) begin
	if (!rst_n) begin
		state <= T_IDLE;
		ofs <= '0;
		chk_ofs <= '0;
		done <= 1'b0;
		fail <= 1'b0;
	end else begin
		case (state)
		T_IDLE:
			if (start) begin
				state <= T_WRITE;
				ofs <= '0;
				done <= 1'b0;
				fail <= 1'b0;
			end
		T_WRITE:
			if (ack) begin
				if (ofs == TW'(`TEST_WORDS - 1)) begin
					ofs <= '0;
					chk_ofs <= '0;
					state <= T_READ;
				end else begin
					ofs <= ofs + 1'b1;
				end
			end
		T_READ:
			if (ack) begin
				ofs <= ofs + TW'(`MEM_BURST);
				state <= T_WAIT;
			end
		T_WAIT:
			if (hit) begin
				// Mismatch stays flagged until the next start
				if (rsp.data != pattern(chk_addr))
					fail <= 1'b1;
				chk_ofs <= chk_ofs + 1'b1;
				if (chk_ofs == TW'(`TEST_WORDS - 1)) begin
					done <= 1'b1;
					state <= T_IDLE;
				end else if (chk_ofs[BW-1:0] == BW'(`MEM_BURST - 1)) begin
					state <= T_READ;
				end
			end
		default:
			state <= T_IDLE;
		endcase
	end
end

endmodule

// ==== scan_reader.sv ====
// Scan reader fetching a frame region in bursts through a small FIFO and streaming pixels
`include "mem_cfg.svh"

module scan_reader import mem_pkg::*; (
	input logic CLOCK_50,
	input logic rst_n,
	input logic enable,
	output logic req,
	output mem_req_t req_data,
	input logic ack,
	input mem_rsp_t rsp,
	output logic [`MEM_DW-1:0] pix,
	output logic pix_valid
);

localparam int AW = `MEM_AW;
localparam int DEPTH = 2 * `MEM_BURST;
localparam int PW = $clog2(DEPTH);
localparam int CNTW = PW + 1;
localparam int NB = `FRAME_WORDS / `MEM_BURST;
localparam int NW = $clog2(NB + 1);

logic [`MEM_DW-1:0] fifo [DEPTH];
logic [PW-1:0] wr_ptr;
logic [PW-1:0] rd_ptr;
logic [CNTW-1:0] count;
// Free entries minus words already requested but not yet arrived
logic [CNTW-1:0] free;
// Bursts requested in the current frame
logic [NW-1:0] bursts;
logic enable_d;
logic push;
logic pop;

assign push = rsp.valid[CL_SCAN];
assign pop = count != '0;

// Room for a full burst and frame not fully requested
assign req = enable && bursts != NW'(NB) && free >= CNTW'(`MEM_BURST);
assign req_data = '{
	addr: AW'(`FRAME_BASE) + AW'(bursts) * AW'(`MEM_BURST),
	data: '0,
	wr: 1'b0
};

always_ff @(posedge CLOCK_50 or negedge rst_n) begin
	if (!rst_n) begin
		enable_d <= 1'b0;
		bursts <= NW'(NB);
		free <= CNTW'(DEPTH);
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
		pix_valid <= 1'b0;
	end else begin
		enable_d <= enable;
		// New frame on each rising edge of enable
		if (enable && !enable_d)
			bursts <= '0;
		else if (ack)
			bursts <= bursts + 1'b1;
		free <= free - (ack ? CNTW'(`MEM_BURST) : '0) + CNTW'(pop);
		if (push)
			wr_ptr <= wr_ptr + 1'b1;
		if (pop)
			rd_ptr <= rd_ptr + 1'b1;
		count <= count + CNTW'(push) - CNTW'(pop);
		pix_valid <= pop;
	end
end

// FIFO storage and pixel output register
always_ff @(posedge CLOCK_50) begin
	if (push)
		fifo[wr_ptr] <= rsp.data;
	pix <= fifo[rd_ptr];
end

endmodule

// ==== mem_subsys.sv ====
// Memory subsystem top with shared RAM, rectangle filler, tester, scan reader and external port
`include "mem_cfg.svh"

module mem_subsys import mem_pkg::*; (
	input logic CLOCK_50,
	input logic rst_n,
	input logic ext_req,
	input mem_req_t ext_req_data,
	output logic ext_ack,
	output mem_rsp_t ext_rsp,
	input logic fill_start,
	output logic fill_active,
	input logic test_start,
	output logic test_done,
	output logic test_fail,
	input logic scan_enable,
	output logic [`MEM_DW-1:0] pix,
	output logic pix_valid
);

// Client request lines, indexed by client id
logic [`MEM_CLIENTS-1:0] req;
logic [`MEM_CLIENTS-1:0] ack;
mem_req_t reqs [`MEM_CLIENTS];
mem_rsp_t rsp;

// External client
assign req[CL_EXT] = ext_req;
assign reqs[CL_EXT] = ext_req_data;
assign ext_ack = ack[CL_EXT];
assign ext_rsp = rsp;

frame_memory i_mem (
	.CLOCK_50(CLOCK_50),
	.rst_n(rst_n),
	.req(req),
	.reqs(reqs),
	.ack(ack),
	.rsp(rsp)
);

rect_fill i_rect (
	.CLOCK_50(CLOCK_50),
	.rst_n(rst_n),
	.start(fill_start),
	.req(req[CL_RECT]),
	.req_data(reqs[CL_RECT]),
	.ack(ack[CL_RECT]),
	.active(fill_active)
);

mem_test i_test (
	.CLOCK_50(CLOCK_50),
	.rst_n(rst_n),
	.start(test_start),
	.req(req[CL_TEST]),
	.req_data(reqs[CL_TEST]),
	.ack(ack[CL_TEST]),
	.rsp(rsp),
	.done(test_done),
	.fail(test_fail)
);

scan_reader i_scan (
	.CLOCK_50(CLOCK_50),
	.rst_n(rst_n),
	.enable(scan_enable),
	.req(req[CL_SCAN]),
	.req_data(reqs[CL_SCAN]),
	.ack(ack[CL_SCAN]),
	.rsp(rsp),
	.pix(pix),
	.pix_valid(pix_valid)
);

endmodule

// ==== tb_mem_subsys.sv ====
// Memory subsystem testbench with clock, reset, memory model, tests, watchdog and summary
`include "mem_cfg.svh"

module tb_mem_subsys import mem_pkg::*; ();

localparam int N_RAND = 24;
// Three other requests ahead, each at most 11 cycles
localparam int ACK_BOUND = (`MEM_CLIENTS - 1) * (`MEM_BURST + 3) + 1;
localparam int EXT_OPS = 3 * N_RAND + 2 * (`FRAME_WORDS + (`FRAME_WORDS + `TEST_WORDS) / `MEM_BURST);
localparam int INT_OPS = `RECT_W * `RECT_H + `TEST_WORDS + (`TEST_WORDS + `FRAME_WORDS) / `MEM_BURST;
localparam int LIMIT = 8 + EXT_OPS * (ACK_BOUND + `MEM_BURST + 4) + 2 * INT_OPS * 11 + 500;

logic CLOCK_50 = 1'b0;
logic rst_n;
logic ext_req;
mem_req_t ext_req_data;
logic ext_ack;
mem_rsp_t ext_rsp;
logic fill_start, fill_active;
logic test_start, test_done, test_fail;
logic scan_enable, pix_valid;
logic [`MEM_DW-1:0] pix;

// Expected RAM content, flagged where a value is known
logic [`MEM_DW-1:0] model [1 << `MEM_AW];
bit known [1 << `MEM_AW];
integer seed = 32'h20c;
int errors = 0;
int err_start;
int tests = 0;
int failed_tests = 0;
string cur_test;

mem_subsys i_dut (.*);

always #20 CLOCK_50 = ~CLOCK_50;

task automatic next_cycle();
	@(posedge CLOCK_50);
	#2;
endtask

task automatic report_value(input string what, input logic [31:0] exp, input logic [31:0] act);
	$display("[ERROR] %s: %s expected %h actual %h", cur_test, what, exp, act);
	errors++;
endtask

task automatic start_test(input string name);
	cur_test = name;
	err_start = errors;
endtask

task automatic finish_test();
	tests++;
	if (errors != err_start)
		failed_tests++;
	$display("Test %s finished with %0d errors", cur_test, errors - err_start);
endtask

// Frame offset inside the border rectangle
function automatic bit in_rect(input int off);
	return off / `LINE_STRIDE >= `RECT_Y && off / `LINE_STRIDE < `RECT_Y + `RECT_H
		&& off % `LINE_STRIDE >= `RECT_X && off % `LINE_STRIDE < `RECT_X + `RECT_W;
endfunction

task automatic fill_model();
	for (int i = 0; i < `FRAME_WORDS; i++)
		if (in_rect(i))
			model[`MEM_AW'(`FRAME_BASE + i)] = `FILL_COLOUR;
endtask

// Holds req until ext_ack, writes update the model
task automatic ext_issue(input logic [`MEM_AW-1:0] a, input logic [`MEM_DW-1:0] d,
		input logic wr);
	int waited;
	waited = 0;
	ext_req_data = '{addr: a, data: d, wr: wr};
	ext_req = 1'b1;
	@(negedge CLOCK_50);
	while (!ext_ack) begin
		waited++;
		@(negedge CLOCK_50);
	end
	next_cycle();
	ext_req = 1'b0;
	if (waited > ACK_BOUND) begin
		$display("[ERROR] %s: ext_ack took %0d cycles, bound is %0d", cur_test, waited, ACK_BOUND);
		errors++;
	end
	if (wr) begin
		model[a] = d;
		known[a] = 1'b1;
	end
endtask

// Burst words expected in cycles 2 to MEM_BURST+1 after ext_ack
task automatic ext_read(input logic [`MEM_AW-1:0] a);
	int words;
	logic [`MEM_AW-1:0] wa;
	words = 0;
	ext_issue(a, '0, 1'b0);
	for (int k = 1; k <= `MEM_BURST + 2; k++) begin
		@(negedge CLOCK_50);
		if (ext_rsp.valid[CL_EXT] != (k >= 2 && k <= `MEM_BURST + 1)) begin
			$display("[ERROR] %s: valid bit wrong %0d cycles after ext_ack", cur_test, k);
			errors++;
		end
		if (ext_rsp.valid[CL_EXT]) begin
			wa = a + `MEM_AW'(words);
			if (known[wa] && ext_rsp.data !== model[wa])
				report_value($sformatf("word %h", wa), model[wa], ext_rsp.data);
			words++;
		end
		next_cycle();
	end
	if (words != `MEM_BURST)
		report_value("words per burst", `MEM_BURST, words);
endtask

// Scratch addresses below the frame region, bursts included
task automatic random_traffic(input int n, input bit mixed);
	logic [31:0] r;
	logic [`MEM_AW-1:0] a;
	for (int i = 0; i < n; i++) begin
		r = $random(seed);
		a = {2'b00, r[25:16]};
		if (a > 12'h3f7)
			a = a - 12'h8;
		if (!mixed || r[31])
			ext_issue(a, r[15:0], 1'b1);
		if (!mixed || !r[31])
			ext_read(a);
	end
endtask

task automatic prefill_frame();
	logic [31:0] r;
	for (int i = 0; i < `FRAME_WORDS; i++) begin
		r = $random(seed);
		ext_issue(`MEM_AW'(`FRAME_BASE + i), r[15:0], 1'b1);
	end
endtask

// Rectangle words may hold either value while the filler runs
task automatic collect_frame(input bit allow_fill);
	int n;
	logic [`MEM_AW-1:0] a;
	n = 0;
	while (n < `FRAME_WORDS) begin
		@(negedge CLOCK_50);
		if (pix_valid) begin
			a = `MEM_AW'(`FRAME_BASE + n);
			if (pix !== model[a] && !(allow_fill && in_rect(n) && pix === `FILL_COLOUR))
				report_value($sformatf("pixel %0d", n), model[a], pix);
			n++;
		end
	end
endtask

initial begin
	rst_n = 1'b0;
	ext_req = 1'b0;
	ext_req_data = '0;
	fill_start = 1'b0;
	test_start = 1'b0;
	scan_enable = 1'b0;
	repeat (8) @(posedge CLOCK_50);
	#2;
	rst_n = 1'b1;

	start_test("reset_state");
	@(negedge CLOCK_50);
	if ({ext_ack, ext_rsp.valid, fill_active, test_done, test_fail, pix_valid} != '0)
		report_value("outputs", '0, {ext_ack, ext_rsp.valid, fill_active, test_done,
			test_fail, pix_valid});
	next_cycle();
	finish_test();

	start_test("random_rw");
	random_traffic(N_RAND, 1'b0);
	finish_test();

	start_test("rect_fill");
	prefill_frame();
	fill_start = 1'b1;
	next_cycle();
	fill_start = 1'b0;
	@(negedge CLOCK_50);
	if (!fill_active)
		report_value("fill_active after start", 1, fill_active);
	while (fill_active)
		@(negedge CLOCK_50);
	next_cycle();
	fill_model();
	for (int i = 0; i < `FRAME_WORDS; i += `MEM_BURST)
		ext_read(`MEM_AW'(`FRAME_BASE + i));
	finish_test();

	start_test("mem_test");
	test_start = 1'b1;
	next_cycle();
	test_start = 1'b0;
	@(negedge CLOCK_50);
	while (!test_done)
		@(negedge CLOCK_50);
	if (test_fail)
		report_value("test_fail", 0, test_fail);
	next_cycle();
	for (int i = 0; i < `TEST_WORDS; i++) begin
		model[`MEM_AW'(`TEST_BASE + i)] = `MEM_DW'(`TEST_BASE + i) ^ 16'h5a5a;
		known[`MEM_AW'(`TEST_BASE + i)] = 1'b1;
	end
	for (int i = 0; i < `TEST_WORDS; i += `MEM_BURST)
		ext_read(`MEM_AW'(`TEST_BASE + i));
	finish_test();

	start_test("scan");
	scan_enable = 1'b1;
	collect_frame(1'b0);
	next_cycle();
	scan_enable = 1'b0;
	finish_test();

	start_test("concurrent");
	prefill_frame();
	fill_start = 1'b1;
	test_start = 1'b1;
	scan_enable = 1'b1;
	next_cycle();
	fill_start = 1'b0;
	test_start = 1'b0;
	fork
		random_traffic(N_RAND, 1'b1);
		collect_frame(1'b1);
		begin
			@(negedge CLOCK_50);
			while (fill_active)
				@(negedge CLOCK_50);
		end
		begin
			@(negedge CLOCK_50);
			while (!test_done)
				@(negedge CLOCK_50);
		end
	join
	next_cycle();
	scan_enable = 1'b0;
	if (test_fail)
		report_value("test_fail", 0, test_fail);
	fill_model();
	for (int i = 0; i < `FRAME_WORDS; i += `MEM_BURST)
		ext_read(`MEM_AW'(`FRAME_BASE + i));
	for (int i = 0; i < `TEST_WORDS; i += `MEM_BURST)
		ext_read(`MEM_AW'(`TEST_BASE + i));
	finish_test();

	$display("Summary: %0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
	if (errors == 0)
		$display("Everything OK");
	else
		$display("Something failed");
	$finish;
end

// Run limit from the summed worst case of all tests
initial begin
	#(LIMIT * 40);
	$display("Watchdog expired after %0d cycles, a test did not finish", LIMIT);
	$display("Something failed");
	$finish;
end

endmodule

// ==== mem_subsys.f ====
+incdir+.
mem_pkg.sv
mem_arbiter.sv
frame_memory.sv
rect_fill.sv
mem_test.sv
scan_reader.sv
mem_subsys.sv
tb_mem_subsys.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_mem_subsys -f mem_subsys.f || exit 1
out=$(./obj_dir/Vtb_mem_subsys)
echo "$out"
echo "$out" | grep -qx "Everything OK" && exit 0 || exit 1
